// File: design/proc_pkg.sv
// Shared definitions for the processor host
// Widths, instruction field positions, opcode and state enums, mixer masks, credits
package proc_pkg;

    // Datapath widths
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 1 << reg_addr_w;
    localparam int mix_w      = 16;
    localparam int byte_w     = 8;
    localparam int sel_w      = 3;

    // Register file reset seed, register i starts at reg_seed + i
    localparam logic [data_w-1:0] reg_seed = 32'h7654_3210;

    // Instruction field positions
    localparam int op_lsb  = 0;
    localparam int op_msb  = 2;
    localparam int rs_lsb  = 5;
    localparam int rs_msb  = 9;
    localparam int rt_lsb  = 10;
    localparam int rt_msb  = 14;
    localparam int sel_lsb = 15;
    localparam int sel_msb = 17;

    // Mixer masks
    localparam logic [15:0] mask_00ff = 16'h00ff;
    localparam logic [7:0]  mask_0f   = 8'h0f;
    localparam logic [15:0] mask_f0f0 = 16'hf0f0;

    // Result credits owned by the host after reset
    localparam int result_credits = 2;
    localparam int credit_w       = $clog2(result_credits + 1);

    typedef logic [credit_w-1:0] credit_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_shl = 3'd5,
        op_shr = 3'd6,
        op_mix = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        st_fetch     = 2'd0,
        st_decode    = 2'd1,
        st_execute   = 2'd2,
        st_writeback = 2'd3
    } host_state_e;

endpackage

// File: design/operand_mixer.sv
`timescale 1ns/1ps
// Combinational operand mixer, five bytes folded into one 16-bit word by select
module operand_mixer (
    input  logic [proc_pkg::byte_w-1:0] a,
    input  logic [proc_pkg::byte_w-1:0] b,
    input  logic [proc_pkg::byte_w-1:0] c,
    input  logic [proc_pkg::byte_w-1:0] d,
    input  logic [proc_pkg::byte_w-1:0] e,
    input  logic [proc_pkg::sel_w-1:0]  sel,
    output logic [proc_pkg::mix_w-1:0]  mix_out
);

    // Byte pairs, first byte in the upper half
    logic [proc_pkg::mix_w-1:0] ab;
    logic [proc_pkg::mix_w-1:0] bc;
    logic [proc_pkg::mix_w-1:0] cd;
    logic [proc_pkg::mix_w-1:0] de;
    logic [proc_pkg::mix_w-1:0] sum5;
    logic [proc_pkg::byte_w-1:0] blend_hi;
    logic [proc_pkg::mix_w-1:0] blend;

    assign ab = {a, b};
    assign bc = {b, c};
    assign cd = {c, d};
    assign de = {d, e};

    // Max 5 * 255, fits easily in 16 bits
    assign sum5 = proc_pkg::mix_w'(a) + proc_pkg::mix_w'(b) + proc_pkg::mix_w'(c)
                + proc_pkg::mix_w'(d) + proc_pkg::mix_w'(e);

    // Low nibble from a, high nibble from b
    assign blend_hi = (a & proc_pkg::mask_0f) | (b & ~proc_pkg::mask_0f);

    // Upper byte kept, lower byte cleared then replaced by d
    assign blend = ({blend_hi, e} & ~proc_pkg::mask_00ff) | {8'h00, d};

    always_comb begin
        case (sel)
            3'd0: mix_out = ab;
            3'd1: mix_out = bc;
            3'd2: mix_out = cd;
            3'd3: mix_out = de;
            3'd4: mix_out = ab ^ cd;
            3'd5: mix_out = (ab & proc_pkg::mask_f0f0) | (de & ~proc_pkg::mask_f0f0);
            3'd6: mix_out = sum5;
            default: mix_out = blend;  // Mode 7
        endcase
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
// 32 x 32 register file with seeded reset, one write port and two async read ports
module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            reg_write,
    input  logic [proc_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [proc_pkg::data_w-1:0]     reg_data,
    input  logic [proc_pkg::reg_addr_w-1:0] rd_addr_a,
    input  logic [proc_pkg::reg_addr_w-1:0] rd_addr_b,
    output logic [proc_pkg::data_w-1:0]     rd_data_a,
    output logic [proc_pkg::data_w-1:0]     rd_data_b
);

    logic [proc_pkg::data_w-1:0] regs [proc_pkg::reg_count];

    // Each register restarts at seed plus its index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < proc_pkg::reg_count; i++) begin
                regs[i] <= proc_pkg::reg_seed + proc_pkg::data_w'(i);
            end
        end else if (reg_write) begin
            regs[reg_addr] <= reg_data;  // Visible on the next edge
        end
    end

    // Combinational reads
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // A write with an unknown index would corrupt an arbitrary register
    a_write_addr_known: assert property (
        @(posedge clk) disable iff (rst)
        reg_write |-> !$isunknown(reg_addr)
    ) else $error("register write with unknown address");

endmodule

// File: design/proc_host.sv
`timescale 1ns/1ps
// Processor host: fetch, decode, execute, writeback FSM with ALU and result credit counter
module proc_host (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            instr_valid,
    input  logic [proc_pkg::data_w-1:0]     instruction,
    output logic                            instr_credit,
    output logic                            result_valid,
    output logic [proc_pkg::data_w-1:0]     result,
    input  logic                            result_credit,
    output logic [proc_pkg::reg_addr_w-1:0] rd_addr_a,
    output logic [proc_pkg::reg_addr_w-1:0] rd_addr_b,
    input  logic [proc_pkg::data_w-1:0]     rd_data_a,
    input  logic [proc_pkg::data_w-1:0]     rd_data_b,
    output logic [proc_pkg::byte_w-1:0]     mix_a,
    output logic [proc_pkg::byte_w-1:0]     mix_b,
    output logic [proc_pkg::byte_w-1:0]     mix_c,
    output logic [proc_pkg::byte_w-1:0]     mix_d,
    output logic [proc_pkg::byte_w-1:0]     mix_e,
    output logic [proc_pkg::sel_w-1:0]      mix_sel,
    input  logic [proc_pkg::mix_w-1:0]      mix_out
);

    proc_pkg::host_state_e state;
    proc_pkg::alu_op_e     op_q;
    proc_pkg::credit_t     credit_cnt;

    logic [proc_pkg::data_w-1:0] cur_instr;
    logic [proc_pkg::byte_w-1:0] prev_lo;  // Low byte of the previous instruction
    logic [proc_pkg::data_w-1:0] op_a;
    logic [proc_pkg::data_w-1:0] op_b;
    logic [proc_pkg::mix_w-1:0]  mix_q;
    logic [proc_pkg::data_w-1:0] alu_res;
    logic [proc_pkg::data_w-1:0] alu_q;
    logic                        spend;

    // Operand addresses come straight from the held instruction
    assign rd_addr_a = cur_instr[proc_pkg::rs_msb:proc_pkg::rs_lsb];
    assign rd_addr_b = cur_instr[proc_pkg::rt_msb:proc_pkg::rt_lsb];

    // Mixer byte sources
    assign mix_a   = rd_data_a[proc_pkg::byte_w-1:0];
    assign mix_b   = rd_data_b[proc_pkg::byte_w-1:0];
    assign mix_c   = prev_lo;
    assign mix_d   = cur_instr[proc_pkg::byte_w-1:0];
    assign mix_e   = {3'b000, rd_addr_a};  // rs index, zero-extended
    assign mix_sel = cur_instr[proc_pkg::sel_msb:proc_pkg::sel_lsb];

    // A result leaves only when a credit is held
    assign spend = (state == proc_pkg::st_writeback) && (credit_cnt != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= proc_pkg::st_fetch;
            cur_instr    <= '0;
            prev_lo      <= '0;
            result_valid <= 1'b0;
            instr_credit <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            instr_credit <= 1'b0;
            case (state)
                proc_pkg::st_fetch: begin
                    if (instr_valid) begin
                        prev_lo   <= cur_instr[proc_pkg::byte_w-1:0];
                        cur_instr <= instruction;
                        state     <= proc_pkg::st_decode;
                    end
                end
                proc_pkg::st_decode: begin
                    state <= proc_pkg::st_execute;
                end
                proc_pkg::st_execute: begin
                    state <= proc_pkg::st_writeback;
                end
                proc_pkg::st_writeback: begin
                    // Stall here while the consumer holds all credits
                    if (spend) begin
                        result_valid <= 1'b1;
                        instr_credit <= 1'b1;  // Upstream may send the next one
                        state        <= proc_pkg::st_fetch;
                    end
                end
                default: state <= proc_pkg::st_fetch;
            endcase
        end
    end

    // Operand and result latches
    always_ff @(posedge clk) begin
        if (state == proc_pkg::st_decode) begin
            op_a  <= rd_data_a;
            op_b  <= rd_data_b;
            mix_q <= mix_out;
            op_q  <= proc_pkg::alu_op_e'(cur_instr[proc_pkg::op_msb:proc_pkg::op_lsb]);
        end
        if (state == proc_pkg::st_execute) begin
            alu_q <= alu_res;
        end
    end

    always_comb begin
        case (op_q)
            proc_pkg::op_add: alu_res = op_a + op_b;
            proc_pkg::op_sub: alu_res = op_a - op_b;
            proc_pkg::op_and: alu_res = op_a & op_b;
            proc_pkg::op_or:  alu_res = op_a | op_b;
            proc_pkg::op_xor: alu_res = op_a ^ op_b;
            proc_pkg::op_shl: alu_res = op_a << op_b[4:0];
            proc_pkg::op_shr: alu_res = op_a >> op_b[4:0];
            default:          alu_res = op_a + {16'h0000, mix_q};  // op_mix
        endcase
    end

    assign result = alu_q;

    // Spend and return in one cycle cancel out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= proc_pkg::credit_t'(proc_pkg::result_credits);
        end else begin
            credit_cnt <= credit_cnt - proc_pkg::credit_t'(spend)
                        + proc_pkg::credit_t'(result_credit);
        end
    end

    // Every result must have been paid for on the edge that raised it
    a_result_has_credit: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |-> $past(credit_cnt) != '0
    ) else $error("result_valid raised with no result credit");

    // Upstream only sends while the host waits in fetch
    a_instr_in_fetch: assert property (
        @(posedge clk) disable iff (rst)
        instr_valid |-> state == proc_pkg::st_fetch
    ) else $error("instruction arrived outside fetch");

endmodule

// File: design/proc_top.sv
`timescale 1ns/1ps
// Top level: processor host, register file and operand mixer
module proc_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            instr_valid,
    input  logic [proc_pkg::data_w-1:0]     instruction,
    input  logic                            reg_write,
    input  logic [proc_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [proc_pkg::data_w-1:0]     reg_data,
    output logic                            instr_credit,
    output logic                            result_valid,
    output logic [proc_pkg::data_w-1:0]     result,
    input  logic                            result_credit
);

    logic [proc_pkg::reg_addr_w-1:0] rd_addr_a;
    logic [proc_pkg::reg_addr_w-1:0] rd_addr_b;
    logic [proc_pkg::data_w-1:0]     rd_data_a;
    logic [proc_pkg::data_w-1:0]     rd_data_b;
    logic [proc_pkg::byte_w-1:0]     mix_a;
    logic [proc_pkg::byte_w-1:0]     mix_b;
    logic [proc_pkg::byte_w-1:0]     mix_c;
    logic [proc_pkg::byte_w-1:0]     mix_d;
    logic [proc_pkg::byte_w-1:0]     mix_e;
    logic [proc_pkg::sel_w-1:0]      mix_sel;
    logic [proc_pkg::mix_w-1:0]      mix_out;

    proc_host u_host (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instruction   (instruction),
        .instr_credit  (instr_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .mix_a         (mix_a),
        .mix_b         (mix_b),
        .mix_c         (mix_c),
        .mix_d         (mix_d),
        .mix_e         (mix_e),
        .mix_sel       (mix_sel),
        .mix_out       (mix_out)
    );

    // Write port driven from outside
    reg_file u_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_data  (reg_data),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    operand_mixer u_mixer (
        .a       (mix_a),
        .b       (mix_b),
        .c       (mix_c),
        .d       (mix_d),
        .e       (mix_e),
        .sel     (mix_sel),
        .mix_out (mix_out)
    );

endmodule

// File: verification/proc_checker.sv
`timescale 1ns/1ps
// Result checker for proc_top: expected queue, result credit bound, per-test lines and counts
module proc_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        result_valid,
    input  logic [proc_pkg::data_w-1:0] result,
    input  logic                        instr_credit,
    input  logic                        result_credit,
    input  logic                        exp_valid,
    input  logic [proc_pkg::data_w-1:0] exp_value,
    input  logic                        run_done,
    input  int                          sent,
    output int                          errors,
    output int                          results_seen,
    output logic                        final_done
);

    logic [proc_pkg::data_w-1:0] exp_q [$];
    logic [proc_pkg::data_w-1:0] want;
    int   err_count     = 0;
    int   seen          = 0;
    int   passed        = 0;
    int   credit_pulses = 0;
    int   outstanding   = 0;  // Results the consumer has not paid back yet
    logic done          = 1'b0;

    assign errors       = err_count;
    assign results_seen = seen;
    assign final_done   = done;

    task automatic print_counts();
        $display("summary: %0d results, %0d passed, %0d errors", seen, passed, err_count);
    endtask

    // Mid-cycle sampling, every DUT output is settled here
    always @(negedge clk) begin
        if (!rst) begin
            if (exp_valid) begin
                exp_q.push_back(exp_value);
            end
            if (instr_credit) begin
                credit_pulses++;
            end
            if (result_valid) begin
                seen++;
                outstanding++;
                if (outstanding > proc_pkg::result_credits) begin
                    $display("result %0d arrived while all %0d result credits were in use",
                             seen, proc_pkg::result_credits);
                    err_count++;
                end
                if (exp_q.size() == 0) begin
                    $display("result %0d (0x%08h) arrived with no instruction waiting for it",
                             seen, result);
                    err_count++;
                end else begin
                    want = exp_q.pop_front();
                    if (result === want) begin
                        passed++;
                        $display("test %0d ok, result 0x%08h", seen, result);
                    end else begin
                        $display("error: result expected 0x%08h got 0x%08h in test %0d",
                                 want, result, seen);
                        err_count++;
                    end
                end
            end
            if (result_credit) begin
                if (outstanding == 0) begin
                    $display("result credit returned while no result was outstanding");
                    err_count++;
                end else begin
                    outstanding--;
                end
            end
            // Closing bookkeeping once the stimulus has drained
            if (run_done && !done) begin
                if (seen != sent) begin
                    $display("%0d results came back for %0d instructions sent", seen, sent);
                    err_count++;
                end
                if (credit_pulses != seen) begin
                    $display("%0d instruction credits came back for %0d results",
                             credit_pulses, seen);
                    err_count++;
                end
                print_counts();
                done = 1'b1;
            end
        end
    end

endmodule

// File: verification/proc_tb.sv
`timescale 1ns/1ps
// Testbench top for proc_top: clock, reset, vector playback, credit handling and watchdog
module proc_tb;

    localparam int          max_vectors = 64;
    localparam logic [31:0] lfsr_seed   = 32'd91612;
    localparam logic [31:0] lfsr_taps   = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    logic                            clk = 1'b0;
    logic                            rst;
    logic                            instr_valid;
    logic [proc_pkg::data_w-1:0]     instruction;
    logic                            reg_write;
    logic [proc_pkg::reg_addr_w-1:0] reg_addr;
    logic [proc_pkg::data_w-1:0]     reg_data;
    logic                            instr_credit;
    logic                            result_valid;
    logic [proc_pkg::data_w-1:0]     result;
    logic                            result_credit;

    // Feed into the checker
    logic                        exp_valid;
    logic [proc_pkg::data_w-1:0] exp_value;
    logic                        run_done;
    logic                        final_done;
    int                          errors;
    int                          results_seen;
    int                          sent;

    logic [31:0] vec_mem [0:4*max_vectors-1];
    logic [31:0] kind;
    logic [31:0] lfsr;
    logic        up_credit;
    logic        setup_fail;
    int          n_vec;
    int          idx;
    int          delay;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          ret_q [$];  // Cycle on which each held result credit goes back

    proc_top UUT (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instruction   (instruction),
        .reg_write     (reg_write),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .instr_credit  (instr_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

    proc_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .result_valid  (result_valid),
        .result        (result),
        .instr_credit  (instr_credit),
        .result_credit (result_credit),
        .exp_valid     (exp_valid),
        .exp_value     (exp_value),
        .run_done      (run_done),
        .sent          (sent),
        .errors        (errors),
        .results_seen  (results_seen),
        .final_done    (final_done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ lfsr_taps;
        end
        return shifted;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    initial begin
        rst           = 1'b1;
        instr_valid   = 1'b0;
        instruction   = '0;
        reg_write     = 1'b0;
        reg_addr      = '0;
        reg_data      = '0;
        result_credit = 1'b0;
        exp_valid     = 1'b0;
        exp_value     = '0;
        run_done      = 1'b0;
        sent          = 0;
        idx           = 0;
        up_credit     = 1'b1;  // Upstream owns one instruction credit
        setup_fail    = 1'b0;
        lfsr          = lfsr_seed;

        $readmemh("verification/proc_vectors.hex", vec_mem);
        n_vec = 0;
        while (n_vec < max_vectors && vec_mem[4*n_vec] != 32'hf) begin
            n_vec++;
        end
        if (n_vec == 0 || n_vec == max_vectors) begin
            $display("no usable vectors in verification/proc_vectors.hex or end marker missing");
            setup_fail = 1'b1;
            n_vec      = 0;
        end
        cycle_limit = n_vec * 20 + 100;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        while (idx < n_vec || results_seen != sent || ret_q.size() != 0) begin
            @(posedge clk);
            #1;
            instr_valid   = 1'b0;
            reg_write     = 1'b0;
            result_credit = 1'b0;
            exp_valid     = 1'b0;
            if (instr_credit) begin
                up_credit = 1'b1;
            end
            if (result_valid) begin
                draw_bits(4, delay);
                ret_q.push_back(cycle_count + delay);
            end
            if (ret_q.size() != 0 && ret_q[0] <= cycle_count) begin
                result_credit = 1'b1;
                void'(ret_q.pop_front());
            end
            // Loads and instructions both wait for an idle host
            if (idx < n_vec && up_credit) begin
                kind = vec_mem[4*idx];
                if (kind == 32'h0) begin
                    reg_write = 1'b1;
                    reg_addr  = vec_mem[4*idx+1][proc_pkg::reg_addr_w-1:0];
                    reg_data  = vec_mem[4*idx+2];
                end else begin
                    instr_valid = 1'b1;
                    instruction = vec_mem[4*idx+2];
                    exp_valid   = 1'b1;
                    exp_value   = vec_mem[4*idx+3];
                    up_credit   = 1'b0;
                    sent++;
                end
                idx++;
            end
        end
        @(posedge clk);
        #1;
        result_credit = 1'b0;
        repeat (4) @(posedge clk);  // Room for a stray duplicate result
        #1;
        run_done = 1'b1;
        wait (final_done);
        if (errors == 0 && !setup_fail) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        #2;
        $display("timeout after %0d cycles with %0d of %0d results seen",
                 cycle_count, results_seen, sent);
        u_checker.print_counts();
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verification/proc_vectors.hex
// Columns are kind, register address, data or instruction word, expected result
// Kind 0 loads a register, kind 1 runs an instruction, kind f ends the list
00000001 00000000 00010827 76543238
00000001 00000000 00001460 eca86428
00000000 00000001 12345678 00000000
00000000 00000002 9abcdef0 00000000
00000000 00000004 0000001f 00000000
00000000 00000006 000000e4 00000000
00000000 00000007 80000001 00000000
00000000 00000008 c3a5965a 00000000
00000000 0000000d 13579bdf 00000000
00000001 00000000 00000820 acf13568
00000001 00000000 00000441 88888878
00000001 00000000 00000821 77777788
00000001 00000000 00000822 12345670
00000001 00000000 00000823 9abcdef8
00000001 00000000 00000824 88888888
00000001 00000000 000010e5 80000000
00000001 00000000 000010e6 00000001
00000001 00000000 00001825 23456780
00000001 00000000 00001846 09abcdef
00000001 00000000 00000826 00001234
00000001 00000000 00000445 f0000000
00000001 00000000 000021a7 13587b39
00000001 00000000 0000a1af 1357f686
00000001 00000000 000121b7 13584b96
00000001 00000000 0001a1bf 13585aec
00000001 00000000 000221a7 1357fcdc
00000001 00000000 0002a1af 13587b3c
00000001 00000000 000321b7 13579e8b
00000001 00000000 0003a1bf 1357fb9e
0000000f 00000000 00000000 00000000

// File: proc_top.f
design/proc_pkg.sv
design/operand_mixer.sv
design/reg_file.sv
design/proc_host.sv
design/proc_top.sv
verification/proc_checker.sv
verification/proc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the proc_top testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module proc_tb \
    -f proc_top.f \
    -o proc_sim

status=0
output=$(./obj_dir/proc_sim) || status=$?
echo "$output"

if grep -qF '*** PASSED ***' <<< "$output"; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed (exit status $status)"
    exit 1
fi
